// ==== bench/vsn_tb.sv ====
`timescale 1ns/1ps
`include "vsn_cfg.svh"

module vsn_tb;
  import vsn_pkg::*;

  localparam int DRIVE_DLY = 10;                       // Input skew after the rising edge
  localparam int N_PAIRS   = 32 + 64 + 64 + 24 + 32;   // Pairs over all tests
  localparam int N_WB      = 8 + 16;                   // Bus accesses over all tests
  localparam int WATCHDOG  = 4 * (N_PAIRS + N_WB) * 20;
  localparam longint SMAX  = (longint'(1) <<< (`VSN_SAMPLE_W - 1)) - 1;
  localparam longint SMIN  = -SMAX - 1;
  // Extreme gains near +2.0 and exactly -2.0
  localparam coef_t CLAMP_M [4] = '{18'sh1FFFF, 18'sh1FFFF, 18'sh20000, 18'sh1FFFF};

  logic       stream_clk, rst_n;
  logic       ch0_valid, ch0_ready, ch1_valid, ch1_ready;
  sample_t    ch0_sample, ch1_sample;
  logic       out_valid, out_ready;
  sample_t    out_b0, out_b1;
  logic       wb_cyc, wb_stb, wb_we, wb_ack;
  logic [1:0] wb_adr;
  coef_t      wb_wdata, wb_rdata;

  coef_t      m_model [4];         // Matrix as last written, by bus address
  coef_t      exp_rdata;           // Expected read data
  sample_t    src0 [$], src1 [$];  // Samples still to send
  sample_t    chq0 [$], chq1 [$];  // Accepted, waiting for the partner
  wave_pair_t model_q [$];         // Expected reflected pairs in order
  wave_pair_t exp_pair;
  logic       head_ok;             // Model has a pair pending
  sample_t    head_b0, head_b1;    // Next expected output
  logic       tx0, tx1, tx_out;    // Handshakes seen mid-cycle
  sample_t    smp0, smp1;
  logic       acc_both;            // Both channels taken this edge
  logic       lat_mode;            // Latency checks armed
  logic       src_done;
  int         ack_cnt, errors, test_errs, tests_pass, tests_fail, seed;

  vsn_top i_vsn_top (.*);

  assign acc_both = ch0_valid & ch0_ready & ch1_valid & ch1_ready;

  initial begin
    stream_clk = 1'b0;
    forever #50 stream_clk = ~stream_clk;  // 100 ns period
  end

  // Guard against a stuck handshake
  initial begin
    repeat (WATCHDOG + 16) @(posedge stream_clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG + 16);
    $display("Regression failed");
    $finish;
  end

  // Reference model sums products, floors by fraction bits and clamps to sample range
  function automatic sample_t reflect(coef_t c0, sample_t x0, coef_t c1, sample_t x1);
    longint acc;
    acc = longint'(c0) * longint'(x0) + longint'(c1) * longint'(x1);
    acc = acc >>> `VSN_COEF_FRAC;  // Arithmetic shift toward minus infinity
    if (acc > SMAX)
      acc = SMAX;
    else if (acc < SMIN)
      acc = SMIN;
    return sample_t'(acc);
  endfunction

  function automatic sample_t full_scale();
    case ($urandom_range(2, 0))
      0:       return sample_t'(SMAX);
      1:       return sample_t'(SMIN);
      default: return sample_t'($urandom());
    endcase
  endfunction

  // Handshakes sampled mid-cycle take effect on the next edge
  always @(negedge stream_clk) begin
    tx0    <= ch0_valid && ch0_ready;
    tx1    <= ch1_valid && ch1_ready;
    tx_out <= out_valid && out_ready;
    smp0   <= ch0_sample;
    smp1   <= ch1_sample;
    if (wb_ack) ack_cnt <= ack_cnt + 1;
  end

  // Model update on the transfer edge
  always @(posedge stream_clk) begin
    if (tx_out && model_q.size() > 0) model_q.delete(0);
    if (tx0) chq0.push_back(smp0);
    if (tx1) chq1.push_back(smp1);
    if (chq0.size() > 0 && chq1.size() > 0) begin  // Join in acceptance order
      exp_pair.w0 = reflect(m_model[0], chq0[0], m_model[1], chq1[0]);
      exp_pair.w1 = reflect(m_model[2], chq0[0], m_model[3], chq1[0]);
      model_q.push_back(exp_pair);
      chq0.delete(0);
      chq1.delete(0);
    end
    head_ok = model_q.size() > 0;
    if (head_ok) begin
      head_b0 = model_q[0].w0;
      head_b1 = model_q[0].w1;
    end
  end

  a_b0: assert property (@(negedge stream_clk) disable iff (!rst_n)
    out_valid && out_ready && head_ok |-> out_b0 == head_b0)
    else begin
      errors = errors + 1;
      $display("FAIL %0t out_b0 expected %0d got %0d", $time, head_b0, out_b0);
    end

  a_b1: assert property (@(negedge stream_clk) disable iff (!rst_n)
    out_valid && out_ready && head_ok |-> out_b1 == head_b1)
    else begin
      errors = errors + 1;
      $display("FAIL %0t out_b1 expected %0d got %0d", $time, head_b1, out_b1);
    end

  a_no_extra: assert property (@(negedge stream_clk) disable iff (!rst_n)
    out_valid && out_ready |-> head_ok)
    else begin
      errors = errors + 1;
      $display("Output pair at %0t with no accepted pair behind it", $time);
    end

  a_stall: assert property (@(negedge stream_clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_b0) && $stable(out_b1))
    else begin
      errors = errors + 1;
      $display("Output moved or dropped during a stall at %0t", $time);
    end

  a_rdata: assert property (@(negedge stream_clk) disable iff (!rst_n)
    wb_ack && !wb_we |-> wb_rdata == exp_rdata)
    else begin
      errors = errors + 1;
      $display("FAIL %0t wb_rdata expected %0h got %0h", $time, exp_rdata, wb_rdata);
    end

  a_ack_next: assert property (@(negedge stream_clk) disable iff (!rst_n)
    wb_cyc && wb_stb && !wb_ack |=> wb_ack)
    else begin
      errors = errors + 1;
      $display("No ack one cycle after the strobe at %0t", $time);
    end

  // Acceptance is sampled half a cycle before its edge, output half a cycle after
  a_lat_out: assert property (@(negedge stream_clk) disable iff (!rst_n)
    lat_mode && out_valid |-> $past(acc_both, 4))
    else begin
      errors = errors + 1;
      $display("Output at %0t without an acceptance three cycles before", $time);
    end

  a_lat_in: assert property (@(negedge stream_clk) disable iff (!rst_n)
    lat_mode && $past(acc_both, 4) |-> out_valid)
    else begin
      errors = errors + 1;
      $display("No output at %0t, three cycles after an acceptance", $time);
    end

  // Sends src0 or src1 on one channel with optional lead and random gaps
  task automatic drive_channel(input int ch, input int n, input int lead, input int gap_max);
    int   i;
    logic taken;
    if (lead > 0) begin
      repeat (lead) @(posedge stream_clk);
      #DRIVE_DLY;
    end
    for (i = 0; i < n; i++) begin
      if (ch == 0) begin
        ch0_valid  = 1'b1;
        ch0_sample = src0[i];
      end else begin
        ch1_valid  = 1'b1;
        ch1_sample = src1[i];
      end
      taken = 1'b0;
      while (!taken) begin
        @(negedge stream_clk);
        taken = (ch == 0) ? ch0_ready : ch1_ready;
        @(posedge stream_clk);
        #DRIVE_DLY;
      end
      if (ch == 0) ch0_valid = 1'b0;
      else ch1_valid = 1'b0;
      if (gap_max > 0) begin
        repeat ($urandom_range(gap_max, 0)) @(posedge stream_clk);
        #DRIVE_DLY;
      end
    end
  endtask

  // Waits until every accepted pair has left the DUT
  task automatic wait_drain();
    @(negedge stream_clk);
    while (model_q.size() != 0 || chq0.size() != 0 || chq1.size() != 0)
      @(negedge stream_clk);
    @(posedge stream_clk);
    #DRIVE_DLY;
  endtask

  task automatic run_stream(input int n, input int lead0, input int lead1,
                            input int gap_max, input logic rnd_ready);
    src_done = 1'b0;
    fork
      begin
        fork
          drive_channel(0, n, lead0, gap_max);
          drive_channel(1, n, lead1, gap_max);
        join
        src_done = 1'b1;
      end
      while (rnd_ready && !src_done) begin  // Random back-pressure
        out_ready = 1'($urandom_range(1, 0));
        @(posedge stream_clk);
        #DRIVE_DLY;
      end
    join
    out_ready = 1'b1;
    wait_drain();
  endtask

  task automatic wb_access(input logic we, input logic [1:0] adr, input coef_t data);
    int acks;
    acks      = ack_cnt;
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = we;
    wb_adr    = adr;
    wb_wdata  = data;
    exp_rdata = m_model[adr];
    @(negedge stream_clk);
    while (!wb_ack) @(negedge stream_clk);
    if (we) m_model[adr] = data;  // Took effect on the ack edge
    @(posedge stream_clk);
    #DRIVE_DLY;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge stream_clk);  // A second ack would land in this cycle
    #DRIVE_DLY;
    a_ack_count: assert (ack_cnt == acks + 1)
      else begin
        errors = errors + 1;
        $display("Bus access at %0t got %0d acks instead of one", $time, ack_cnt - acks);
      end
  endtask

  task automatic finish_test(input string name);
    int n;
    n = errors - test_errs;
    if (n == 0) tests_pass = tests_pass + 1;
    else tests_fail = tests_fail + 1;
    $display("Test %0d %s: %s, %0d errors", tests_pass + tests_fail, name,
             (n == 0) ? "ok" : "errors found", n);
    test_errs = errors;
    src0.delete();
    src1.delete();
  endtask

  initial begin
    int i, k;
    seed       = $urandom(32'h6353);
    rst_n      = 1'b0;
    ch0_valid  = 1'b0;
    ch1_valid  = 1'b0;
    ch0_sample = '0;
    ch1_sample = '0;
    out_ready  = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_wdata   = '0;
    tx0        = 1'b0;
    tx1        = 1'b0;
    tx_out     = 1'b0;
    head_ok    = 1'b0;
    lat_mode   = 1'b0;
    ack_cnt    = 0;
    errors     = 0;
    test_errs  = 0;
    tests_pass = 0;
    tests_fail = 0;
    m_model[0] = '0;
    m_model[1] = 18'sh10000;  // 1.0 for the through connection
    m_model[2] = 18'sh10000;
    m_model[3] = '0;
    repeat (16) @(posedge stream_clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(posedge stream_clk);
    #DRIVE_DLY;

    // Both channels open, nothing offered yet
    a_reset_state: assert (ch0_ready && ch1_ready && !out_valid && !wb_ack)
      else begin
        errors = errors + 1;
        $display("Ready, valid or ack wrong after reset at %0t", $time);
      end

    // Default matrix swaps the ports
    for (i = 0; i < 32; i++) begin
      src0.push_back(sample_t'($rtoi(24000.0 * $sin(6.2831853 * i / 16.0))));
      src1.push_back(sample_t'($rtoi(16000.0 * $cos(6.2831853 * i / 12.0))));
    end
    run_stream(32, 0, 0, 0, 1'b0);
    finish_test("default through");

    for (k = 0; k < 4; k++)
      wb_access(1'b1, 2'(k), coef_t'($urandom()));
    for (k = 0; k < 4; k++)
      wb_access(1'b0, 2'(k), '0);
    finish_test("coefficient readback");

    // First matrix forces both clamp limits
    for (k = 0; k < 4; k++) begin
      for (i = 0; i < 4; i++)
        wb_access(1'b1, 2'(i), (k == 0) ? CLAMP_M[i] : coef_t'($urandom()));
      src0.delete();
      src1.delete();
      src0.push_back(sample_t'(SMAX));
      src1.push_back(sample_t'(SMAX));
      src0.push_back(sample_t'(SMIN));
      src1.push_back(sample_t'(SMIN));
      src0.push_back(sample_t'(SMAX));
      src1.push_back(sample_t'(SMIN));
      for (i = 3; i < 16; i++) begin
        src0.push_back(full_scale());
        src1.push_back(full_scale());
      end
      run_stream(16, 0, 0, 0, 1'b0);
    end
    finish_test("saturating random matrices");

    for (i = 0; i < 64; i++) begin
      src0.push_back(sample_t'($urandom()));
      src1.push_back(sample_t'($urandom()));
    end
    run_stream(64, 0, 0, 1, 1'b1);
    finish_test("random back-pressure");

    for (i = 0; i < 12; i++) begin
      src0.push_back(sample_t'($urandom()));
      src1.push_back(sample_t'($urandom()));
    end
    run_stream(12, 0, 5, 2, 1'b0);  // Channel 1 late
    run_stream(12, 5, 0, 2, 1'b0);  // Channel 0 late with the same samples
    finish_test("skewed channels");

    for (i = 0; i < 32; i++) begin
      src0.push_back(sample_t'($urandom()));
      src1.push_back(sample_t'($urandom()));
    end
    lat_mode = 1'b1;
    run_stream(32, 0, 0, 0, 1'b0);
    lat_mode = 1'b0;
    finish_test("latency and throughput");

    $display("Tests passed %0d, failed %0d", tests_pass, tests_fail);
    if (tests_fail == 0 && errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module vsn_tb -o vsn_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/vsn_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench reported it
if grep -q "Regression passed" <<< "$output"; then
  exit 0
fi
echo "Pass message not found"
exit 1

// ==== tb.f ====
+incdir+verilog
verilog/vsn_pkg.sv
verilog/vsn_port.sv
verilog/vsn_rfdc_adapter.sv
verilog/vsn_sparam_regs.sv
verilog/vsn_sparam_2port.sv
verilog/vsn_top.sv
bench/vsn_tb.sv

// ==== verilog/vsn_cfg.svh ====
`ifndef VSN_CFG_SVH
`define VSN_CFG_SVH

// Virtual scattering network sizing

// Wave sample width as delivered by the data converters
`define VSN_SAMPLE_W 16

// Signed fixed-point S-matrix entry width
`define VSN_COEF_W 18

// Coefficient fraction bits so 1.0 is 1 << 16
`define VSN_COEF_FRAC 16

// Ports of the network
// Only the two-port case is built
`define VSN_NPORT 2

`endif

// ==== verilog/vsn_pkg.sv ====
`include "vsn_cfg.svh"

package vsn_pkg;

  // One incident or reflected wave sample
  typedef logic signed [`VSN_SAMPLE_W-1:0] sample_t;

  // S-matrix entry in 18-bit signed fixed point
  typedef logic signed [`VSN_COEF_W-1:0] coef_t;

  // Row is the reflected port, column the incident port
  typedef coef_t smatrix_t [`VSN_NPORT][`VSN_NPORT];

  // One sample per network port
  typedef struct packed {
    sample_t w0;  // Port 0 wave
    sample_t w1;  // Port 1 wave
  } wave_pair_t;

endpackage

// ==== verilog/vsn_port.sv ====
`timescale 1ns/1ps

// Wave pair stream with valid/ready handshake
interface vsn_port;
  import vsn_pkg::*;

  logic    valid;  // Producer has a pair
  logic    ready;  // Consumer takes it this edge
  sample_t w0;     // Port 0 wave
  sample_t w1;     // Port 1 wave

  // Producer side
  modport P (
    output valid,
    output w0,
    output w1,
    input  ready
  );

  // Consumer side
  modport U (
    input  valid,
    input  w0,
    input  w1,
    output ready
  );

endinterface

// ==== verilog/vsn_rfdc_adapter.sv ====
`timescale 1ns/1ps

// Joins two converter channels into one wave pair stream
module vsn_rfdc_adapter (
  input  logic             stream_clk,
  input  logic             rst_n,
  input  logic             ch0_valid,
  output logic             ch0_ready,
  input  vsn_pkg::sample_t ch0_sample,
  input  logic             ch1_valid,
  output logic             ch1_ready,
  input  vsn_pkg::sample_t ch1_sample,
  vsn_port.P               vsn
);
  import vsn_pkg::*;

  logic       held0, held1;  // Channel sample waiting for its partner
  sample_t    hold0, hold1;  // Held samples
  logic       acc0, acc1;    // Channel transfers this edge
  logic       load;          // Move held pair to output register
  logic       pair_valid;    // Output register occupied
  wave_pair_t pair_q;        // Output register

  // Output slot is free, or frees on this edge
  assign load = held0 & held1 & (~pair_valid | vsn.ready);

  // A slot clearing this edge can take the next sample at once
  assign ch0_ready = ~held0 | load;
  assign ch1_ready = ~held1 | load;
  assign acc0 = ch0_valid & ch0_ready;
  assign acc1 = ch1_valid & ch1_ready;

  always_ff @(posedge stream_clk or negedge rst_n) begin
    if (!rst_n) begin
      held0      <= 1'b0;
      held1      <= 1'b0;
      pair_valid <= 1'b0;
    end else begin
      if (acc0) held0 <= 1'b1;
      else if (load) held0 <= 1'b0;
      if (acc1) held1 <= 1'b1;
      else if (load) held1 <= 1'b0;
      if (load) pair_valid <= 1'b1;
      else if (vsn.ready) pair_valid <= 1'b0;  // Transfer empties it
    end
  end

  // Sample and pair data
  always_ff @(posedge stream_clk) begin
    if (acc0) hold0 <= ch0_sample;
    if (acc1) hold1 <= ch1_sample;
    if (load) pair_q <= '{w0: hold0, w1: hold1};  // Old samples while new ones land in hold
  end

  assign vsn.valid = pair_valid;
  assign vsn.w0    = pair_q.w0;
  assign vsn.w1    = pair_q.w1;

  // Offered pair must not change or vanish under back-pressure
  a_pair_hold: assert property (@(posedge stream_clk) disable iff (!rst_n)
    vsn.valid && !vsn.ready |=> vsn.valid && $stable(pair_q));

endmodule

// ==== verilog/vsn_sparam_2port.sv ====
`timescale 1ns/1ps
`include "vsn_cfg.svh"

// Two-port scattering stage
// b0 = S00*a0 + S01*a1, b1 = S10*a0 + S11*a1
module vsn_sparam_2port (
  input  logic              stream_clk,
  input  logic              rst_n,
  input  vsn_pkg::smatrix_t s_matrix,
  vsn_port.U                a,
  output logic              out_valid,
  input  logic              out_ready,
  output vsn_pkg::sample_t  out_b0,
  output vsn_pkg::sample_t  out_b1
);
  import vsn_pkg::*;

  localparam int PROD_W = `VSN_SAMPLE_W + `VSN_COEF_W;  // Full product width
  localparam int SUM_W  = PROD_W + 1;                   // Room for the carry

  // Sample range in sum width
  localparam logic signed [SUM_W-1:0] SAMPLE_MAX = 2 ** (`VSN_SAMPLE_W - 1) - 1;
  localparam logic signed [SUM_W-1:0] SAMPLE_MIN = -(2 ** (`VSN_SAMPLE_W - 1));

  logic                      pipe_en;        // Advance both stages
  logic                      v1;             // Stage 1 holds products
  logic signed [PROD_W-1:0]  prod_q [2][2];  // [out port][in port]
  logic signed [SUM_W-1:0]   sum0, sum1;     // Unscaled reflected waves
  wave_pair_t                b_q;            // Stage 2 result
  logic                      v2;             // Stage 2 holds a result

  // Floor to integer then clamp to the sample range
  function automatic sample_t sat_shift(input logic signed [SUM_W-1:0] s);
    logic signed [SUM_W-1:0] q;
    q = s >>> `VSN_COEF_FRAC;  // Arithmetic shift rounds toward minus infinity
    if (q > SAMPLE_MAX)
      return sample_t'(SAMPLE_MAX);
    else if (q < SAMPLE_MIN)
      return sample_t'(SAMPLE_MIN);
    else
      return sample_t'(q);
  endfunction

  // Whole pipe freezes while the output is refused
  assign pipe_en = ~(v2 & ~out_ready);
  assign a.ready = pipe_en;  // Drops in the same cycle as the stall

  always_ff @(posedge stream_clk or negedge rst_n) begin
    if (!rst_n) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else if (pipe_en) begin
      v1 <= a.valid;  // Ready is high here, so valid means transfer
      v2 <= v1;
    end
  end

  // Stage 1 registers four full-width products
  always_ff @(posedge stream_clk) begin
    if (pipe_en) begin
      prod_q[0][0] <= s_matrix[0][0] * a.w0;
      prod_q[0][1] <= s_matrix[0][1] * a.w1;
      prod_q[1][0] <= s_matrix[1][0] * a.w0;
      prod_q[1][1] <= s_matrix[1][1] * a.w1;
    end
  end

  // Sign-extended sums per output port
  always_comb begin
    sum0 = prod_q[0][0] + prod_q[0][1];
    sum1 = prod_q[1][0] + prod_q[1][1];
  end

  // Stage 2 scales and saturates
  always_ff @(posedge stream_clk) begin
    if (pipe_en) begin
      b_q.w0 <= sat_shift(sum0);
      b_q.w1 <= sat_shift(sum1);
    end
  end

  assign out_valid = v2;
  assign out_b0    = b_q.w0;
  assign out_b1    = b_q.w1;

  // Held output keeps its value until taken
  a_out_hold: assert property (@(posedge stream_clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_b0) && $stable(out_b1));

endmodule

// ==== verilog/vsn_sparam_regs.sv ====
`timescale 1ns/1ps
`include "vsn_cfg.svh"

// Wishbone classic slave for the 2x2 scattering matrix
// Address 0 = S00, 1 = S01, 2 = S10, 3 = S11
module vsn_sparam_regs (
  input  logic              stream_clk,
  input  logic              rst_n,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [1:0]        wb_adr,
  input  vsn_pkg::coef_t    wb_wdata,
  output vsn_pkg::coef_t    wb_rdata,
  output logic              wb_ack,
  output vsn_pkg::smatrix_t s_matrix
);
  import vsn_pkg::*;

  // Unity gain in Q1.16
  localparam coef_t COEF_ONE = coef_t'(1) <<< `VSN_COEF_FRAC;

  smatrix_t s_q;      // Coefficient store
  logic     req;      // New access this cycle
  logic     row, col; // Matrix position of the address
  coef_t    rdata_q;  // Read data held for the ack cycle

  // New access only while ack is low
  assign req = wb_cyc & wb_stb & ~wb_ack;
  assign row = wb_adr[1];
  assign col = wb_adr[0];

  always_ff @(posedge stream_clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack  <= 1'b0;
      s_q[0][0] <= '0;        // No reflection at port 0
      s_q[0][1] <= COEF_ONE;  // Port 1 passes to port 0
      s_q[1][0] <= COEF_ONE;  // Port 0 passes to port 1
      s_q[1][1] <= '0;
    end else begin
      wb_ack <= req;  // Single-cycle ack
      if (req && wb_we)
        s_q[row][col] <= wb_wdata;  // Lands on the ack edge
    end
  end

  // Read data valid only with ack
  always_ff @(posedge stream_clk) begin
    if (req)
      rdata_q <= s_q[row][col];
  end

  assign wb_rdata = rdata_q;
  assign s_matrix = s_q;  // Full matrix always visible

  // Every ack answers a strobe seen one cycle earlier
  a_ack_req: assert property (@(posedge stream_clk) disable iff (!rst_n)
    wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

// ==== verilog/vsn_top.sv ====
`timescale 1ns/1ps

// Virtual two-port network from channel inputs to reflected wave output
module vsn_top (
  input  logic             stream_clk,
  input  logic             rst_n,
  // Channel 0 carries incident wave a0
  input  logic             ch0_valid,
  output logic             ch0_ready,
  input  vsn_pkg::sample_t ch0_sample,
  // Channel 1 carries incident wave a1
  input  logic             ch1_valid,
  output logic             ch1_ready,
  input  vsn_pkg::sample_t ch1_sample,
  // Reflected pair
  output logic             out_valid,
  input  logic             out_ready,
  output vsn_pkg::sample_t out_b0,
  output vsn_pkg::sample_t out_b1,
  // Coefficient access
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [1:0]       wb_adr,
  input  vsn_pkg::coef_t   wb_wdata,
  output vsn_pkg::coef_t   wb_rdata,
  output logic             wb_ack
);
  import vsn_pkg::*;

  smatrix_t s_matrix;  // Live coefficients

  vsn_port a_waves ();  // Incident pair from adapter to network

  vsn_rfdc_adapter i_adapter (
    .stream_clk (stream_clk),
    .rst_n      (rst_n),
    .ch0_valid  (ch0_valid),
    .ch0_ready  (ch0_ready),
    .ch0_sample (ch0_sample),
    .ch1_valid  (ch1_valid),
    .ch1_ready  (ch1_ready),
    .ch1_sample (ch1_sample),
    .vsn        (a_waves.P)
  );

  vsn_sparam_regs i_regs (
    .stream_clk (stream_clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_wdata   (wb_wdata),
    .wb_rdata   (wb_rdata),
    .wb_ack     (wb_ack),
    .s_matrix   (s_matrix)
  );

  vsn_sparam_2port i_sparam (
    .stream_clk (stream_clk),
    .rst_n      (rst_n),
    .s_matrix   (s_matrix),
    .a          (a_waves.U),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_b0     (out_b0),
    .out_b1     (out_b1)
  );

endmodule
